/* design/mem_pkg.sv */
// shared widths, memory map constants, enums and request/response structs
`default_nettype none

package mem_pkg;

    localparam int unsigned XLEN   = 32;  // data and address width
    localparam int unsigned STRB_W = 4;   // one strobe bit per byte

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [STRB_W-1:0] strb_t;

    typedef enum logic [1:0] {
        OP_PLAIN,  // ordinary load or store
        OP_LR,     // load-reserved
        OP_SC      // store-conditional
    } atomic_op_e;

    typedef enum logic [1:0] {
        REG_DMEM,
        REG_PERF,
        REG_HART,
        REG_NONE  // reads zero, writes dropped
    } region_e;

    // address bits 30..28 select the region
    localparam logic [2:0] REGION_DMEM      = 3'b001;  // 0x1xxxxxxx
    localparam logic [2:0] REGION_PERF_HART = 3'b100;  // 0x4000xxxx
    localparam int unsigned HART_SEL_BIT    = 12;      // 0 perf, 1 hart index

    typedef struct packed {
        logic       we;
        atomic_op_e op;
        word_t      addr;
        word_t      wdata;
        strb_t      wstrb;
    } core_req_t;

    typedef struct packed {
        word_t rdata;
        logic  sc_ok;  // only meaningful for an SC
    } core_resp_t;

    // request as held in the arbiter buffers
    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
        strb_t wstrb;
    } dmem_req_t;

endpackage

`default_nettype wire

/* design/dmem_ram.sv */
// dual-port word RAM with byte strobes and registered reads
`timescale 1ns/1ps
`default_nettype none

module dmem_ram #(
    parameter int unsigned DMEM_WORDS = 1024
) (
    input  logic           clk_i,
    input  logic           en_a_i,
    input  logic           we_a_i,
    input  mem_pkg::word_t addr_a_i,
    input  mem_pkg::word_t wdata_a_i,
    input  mem_pkg::strb_t wstrb_a_i,
    output mem_pkg::word_t rdata_a_o,
    input  logic           en_b_i,
    input  logic           we_b_i,
    input  mem_pkg::word_t addr_b_i,
    input  mem_pkg::word_t wdata_b_i,
    input  mem_pkg::strb_t wstrb_b_i,
    output mem_pkg::word_t rdata_b_o
);

    localparam int unsigned AW = $clog2(DMEM_WORDS);

    mem_pkg::word_t mem [DMEM_WORDS] = '{default: '0};
    logic [AW-1:0]  idx_a;
    logic [AW-1:0]  idx_b;

    assign idx_a = addr_a_i[AW+1:2];  // byte address to word index
    assign idx_b = addr_b_i[AW+1:2];

    // the arbiter never puts both ports on one word
    always_ff @(posedge clk_i) begin
        if (en_a_i) begin
            for (int b = 0; b < mem_pkg::STRB_W; b++) begin
                if (we_a_i && wstrb_a_i[b]) begin
                    mem[idx_a][8*b +: 8] <= wdata_a_i[8*b +: 8];
                end
            end
            rdata_a_o <= mem[idx_a];  // old data on a write
        end
        if (en_b_i) begin
            for (int b = 0; b < mem_pkg::STRB_W; b++) begin
                if (we_b_i && wstrb_b_i[b]) begin
                    mem[idx_b][8*b +: 8] <= wdata_b_i[8*b +: 8];
                end
            end
            rdata_b_o <= mem[idx_b];
        end
    end

endmodule

`default_nettype wire

/* design/dmem_arbiter.sv */
// per-core request buffers, two-port round-robin selection and response return
`timescale 1ns/1ps
`default_nettype none

module dmem_arbiter #(
    parameter int unsigned NCORES     = 2,
    parameter int unsigned DMEM_WORDS = 1024
) (
    input  logic                              clk_i,
    input  logic                              rst,
    input  logic               [NCORES-1:0]   valid_i,
    input  mem_pkg::dmem_req_t [NCORES-1:0]   req_i,
    output logic               [NCORES-1:0]   done_o,
    output mem_pkg::word_t     [NCORES-1:0]   rdata_o
);

    localparam int unsigned IDX_W = (NCORES > 1) ? $clog2(NCORES) : 1;

    logic               [NCORES-1:0] buf_valid;
    mem_pkg::dmem_req_t [NCORES-1:0] buf_req;
    logic               [NCORES-1:0] served;
    logic [IDX_W-1:0] rr_ptr;        // first core looked at
    logic [IDX_W-1:0] sel_a;
    logic [IDX_W-1:0] sel_b;
    logic             sel_valid_a;
    logic             sel_valid_b;
    logic [IDX_W-1:0] resp_core_a;   // owner of the word coming out of port a
    logic [IDX_W-1:0] resp_core_b;
    logic             resp_valid_a;
    logic             resp_valid_b;
    mem_pkg::word_t   ram_rdata_a;
    mem_pkg::word_t   ram_rdata_b;

    // capture stage
    always_ff @(posedge clk_i) begin
        if (rst) begin
            buf_valid <= '0;
        end else begin
            for (int i = 0; i < NCORES; i++) begin
                if (valid_i[i]) begin
                    buf_valid[i] <= 1'b1;
                end else if (served[i]) begin
                    buf_valid[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NCORES; i++) begin
            if (valid_i[i]) begin
                buf_req[i] <= req_i[i];
            end
        end
    end

    // port b takes the next pending core on a different word
    always_comb begin : select
        int idx;
        sel_valid_a = 1'b0;
        sel_valid_b = 1'b0;
        sel_a       = '0;
        sel_b       = '0;
        for (int k = 0; k < NCORES; k++) begin
            idx = (int'(rr_ptr) + k) % NCORES;
            if (buf_valid[idx] && !sel_valid_a) begin
                sel_a       = IDX_W'(idx);
                sel_valid_a = 1'b1;
            end
        end
        for (int k = 0; k < NCORES; k++) begin
            idx = (int'(rr_ptr) + k) % NCORES;
            if (buf_valid[idx] && sel_valid_a && !sel_valid_b && idx != int'(sel_a) &&
                buf_req[idx].addr[31:2] != buf_req[sel_a].addr[31:2]) begin
                sel_b       = IDX_W'(idx);
                sel_valid_b = 1'b1;
            end
        end
    end

    for (genvar i = 0; i < NCORES; i++) begin : gen_served
        assign served[i] = (sel_valid_a && sel_a == IDX_W'(i)) ||
                           (sel_valid_b && sel_b == IDX_W'(i));
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            rr_ptr       <= '0;
            resp_valid_a <= 1'b0;
            resp_valid_b <= 1'b0;
        end else begin
            if (sel_valid_b) begin
                rr_ptr <= IDX_W'((int'(sel_b) + 1) % NCORES);
            end else if (sel_valid_a) begin
                rr_ptr <= IDX_W'((int'(sel_a) + 1) % NCORES);
            end
            resp_valid_a <= sel_valid_a;
            resp_valid_b <= sel_valid_b;
        end
    end

    always_ff @(posedge clk_i) begin
        resp_core_a <= sel_a;
        resp_core_b <= sel_b;
    end

    dmem_ram #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_ram (
        .clk_i    (clk_i),
        .en_a_i   (sel_valid_a),
        .we_a_i   (sel_valid_a && buf_req[sel_a].we),
        .addr_a_i (buf_req[sel_a].addr),
        .wdata_a_i(buf_req[sel_a].wdata),
        .wstrb_a_i(buf_req[sel_a].wstrb),
        .rdata_a_o(ram_rdata_a),
        .en_b_i   (sel_valid_b),
        .we_b_i   (sel_valid_b && buf_req[sel_b].we),
        .addr_b_i (buf_req[sel_b].addr),
        .wdata_b_i(buf_req[sel_b].wdata),
        .wstrb_b_i(buf_req[sel_b].wstrb),
        .rdata_b_o(ram_rdata_b)
    );

    // registered read word back to the owning core
    always_ff @(posedge clk_i) begin
        if (rst) begin
            done_o <= '0;
        end else begin
            for (int i = 0; i < NCORES; i++) begin
                done_o[i] <= (resp_valid_a && resp_core_a == IDX_W'(i)) ||
                             (resp_valid_b && resp_core_b == IDX_W'(i));
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NCORES; i++) begin
            rdata_o[i] <= (resp_valid_a && resp_core_a == IDX_W'(i)) ? ram_rdata_a
                                                                      : ram_rdata_b;
        end
    end

endmodule

`default_nettype wire

/* design/perf_counter.sv */
// 64-bit cycle counter with a 2-bit mode register and registered word readback
`timescale 1ns/1ps
`default_nettype none

module perf_counter (
    input  logic           clk_i,
    input  logic           rst,
    input  logic           wr_i,
    input  logic [3:0]     rd_offset_i,
    input  mem_pkg::word_t wdata_i,
    output mem_pkg::word_t rdata_o
);

    logic [1:0]  mode_q;   // 0 clear, 1 run, 2/3 freeze
    logic [63:0] mcycle_q;

    always_ff @(posedge clk_i) begin
        if (rst) begin
            mode_q   <= 2'd0;
            mcycle_q <= '0;
        end else begin
            if (wr_i && rd_offset_i == 4'd0) begin
                mode_q <= wdata_i[1:0];
            end
            case (mode_q)
                2'd0:    mcycle_q <= '0;
                2'd1:    mcycle_q <= mcycle_q + 64'd1;
                default: mcycle_q <= mcycle_q;  // frozen
            endcase
        end
    end

    // offset 4 gives the low word, offset 0 the high word
    always_ff @(posedge clk_i) begin
        rdata_o <= rd_offset_i[2] ? mcycle_q[31:0] : mcycle_q[63:32];
    end

endmodule

`default_nettype wire

/* design/lrsc_monitor.sv */
// per-core LR reservations and store-conditional success flags
`timescale 1ns/1ps
`default_nettype none

module lrsc_monitor #(
    parameter int unsigned NCORES = 2
) (
    input  logic                          clk_i,
    input  logic                          rst,
    input  logic           [NCORES-1:0]   lr_i,
    input  logic           [NCORES-1:0]   sc_i,
    input  logic           [NCORES-1:0]   store_i,
    input  mem_pkg::word_t [NCORES-1:0]   addr_i,
    output logic           [NCORES-1:0]   sc_ok_o
);

    logic [NCORES-1:0]         resv_valid;
    logic [mem_pkg::XLEN-3:0]  resv_addr [NCORES];  // reserved word address

    always_ff @(posedge clk_i) begin
        if (rst) begin
            resv_valid <= '0;
        end else begin
            for (int i = 0; i < NCORES; i++) begin
                if (lr_i[i]) begin
                    resv_valid[i] <= 1'b1;
                end
                if (sc_i[i]) begin
                    resv_valid[i] <= 1'b0;  // cleared on success or failure
                end
                // a write by any other core to the word breaks the reservation
                for (int j = 0; j < NCORES; j++) begin
                    if (j != i && store_i[j] && addr_i[j][31:2] == resv_addr[i]) begin
                        resv_valid[i] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NCORES; i++) begin
            if (lr_i[i]) begin
                resv_addr[i] <= addr_i[i][31:2];
            end
        end
    end

    for (genvar i = 0; i < NCORES; i++) begin : gen_sc_ok
        assign sc_ok_o[i] = resv_valid[i] && addr_i[i][31:2] == resv_addr[i];
    end

endmodule

`default_nettype wire

/* design/bus_decoder.sv */
// per-core address decoder with response routing, hart index and perf counter
`timescale 1ns/1ps
`default_nettype none

module bus_decoder #(
    parameter int unsigned HART_ID = 0
) (
    input  logic                clk_i,
    input  logic                rst,
    input  logic                req_i,
    input  mem_pkg::core_req_t  req_data_i,
    input  logic                sc_ok_i,
    input  logic                dmem_done_i,
    input  mem_pkg::word_t      dmem_rdata_i,
    output logic                dmem_valid_o,
    output mem_pkg::dmem_req_t  dmem_req_o,
    output logic                store_o,
    output logic                lr_o,
    output logic                sc_o,
    output logic                done_o,
    output mem_pkg::core_resp_t resp_o
);

    mem_pkg::region_e region;
    mem_pkg::region_e region_q;  // region of the pending access
    logic             accept;
    logic             is_dmem;
    logic             is_sc;
    logic             wr_en;
    logic             inflight_q;    // waiting on the arbiter
    logic             local_done_q;
    logic             sc_ok_q;
    mem_pkg::word_t   perf_rdata;

    always_comb begin
        if (req_data_i.addr[30:28] == mem_pkg::REGION_DMEM) begin
            region = mem_pkg::REG_DMEM;
        end else if (req_data_i.addr[30:28] == mem_pkg::REGION_PERF_HART) begin
            region = req_data_i.addr[mem_pkg::HART_SEL_BIT] ? mem_pkg::REG_HART
                                                            : mem_pkg::REG_PERF;
        end else begin
            region = mem_pkg::REG_NONE;
        end
    end

    // a request is taken once, never in its own done cycle
    assign accept  = req_i && !inflight_q && !done_o;
    assign is_dmem = region == mem_pkg::REG_DMEM;
    assign is_sc   = is_dmem && req_data_i.op == mem_pkg::OP_SC;
    assign wr_en   = req_data_i.we && (!is_sc || sc_ok_i);  // failed SC writes nothing

    assign dmem_valid_o     = accept && is_dmem;
    assign dmem_req_o.we    = wr_en;
    assign dmem_req_o.addr  = req_data_i.addr;
    assign dmem_req_o.wdata = req_data_i.wdata;
    assign dmem_req_o.wstrb = req_data_i.wstrb;

    assign store_o = accept && is_dmem && wr_en;
    assign lr_o    = accept && is_dmem && req_data_i.op == mem_pkg::OP_LR;
    assign sc_o    = accept && is_sc;

    always_ff @(posedge clk_i) begin
        if (rst) begin
            inflight_q   <= 1'b0;
            local_done_q <= 1'b0;
            sc_ok_q      <= 1'b0;
            region_q     <= mem_pkg::REG_NONE;
        end else begin
            local_done_q <= accept && !is_dmem;
            if (accept) begin
                region_q <= region;
                sc_ok_q  <= is_sc && sc_ok_i;  // sampled at decode
            end
            if (accept && is_dmem) begin
                inflight_q <= 1'b1;
            end else if (dmem_done_i) begin
                inflight_q <= 1'b0;
            end
        end
    end

    perf_counter u_perf (
        .clk_i      (clk_i),
        .rst        (rst),
        .wr_i       (accept && region == mem_pkg::REG_PERF && req_data_i.we),
        .rd_offset_i(req_data_i.addr[3:0]),
        .wdata_i    (req_data_i.wdata),
        .rdata_o    (perf_rdata)
    );

    always_comb begin
        case (region_q)
            mem_pkg::REG_DMEM: resp_o.rdata = dmem_rdata_i;
            mem_pkg::REG_PERF: resp_o.rdata = perf_rdata;
            mem_pkg::REG_HART: resp_o.rdata = mem_pkg::word_t'(HART_ID);
            default:           resp_o.rdata = '0;  // unmapped
        endcase
    end

    assign resp_o.sc_ok = sc_ok_q;
    assign done_o       = local_done_q || dmem_done_i;

endmodule

`default_nettype wire

/* design/mem_subsystem.sv */
// top level of the memory subsystem: per-core decoders, data memory arbiter, LR/SC monitor
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem #(
    parameter int unsigned NCORES     = 2,
    parameter int unsigned DMEM_WORDS = 1024
) (
    input  logic                                clk_i,
    input  logic                                rst,
    input  logic               [NCORES-1:0]     req_i,
    input  mem_pkg::core_req_t [NCORES-1:0]     req_data_i,
    output logic               [NCORES-1:0]     done_o,
    output mem_pkg::core_resp_t [NCORES-1:0]    resp_o
);

    logic                [NCORES-1:0] dmem_valid;
    mem_pkg::dmem_req_t  [NCORES-1:0] dmem_req;
    logic                [NCORES-1:0] dmem_done;
    mem_pkg::word_t      [NCORES-1:0] dmem_rdata;
    logic                [NCORES-1:0] store;
    logic                [NCORES-1:0] lr;
    logic                [NCORES-1:0] sc;
    logic                [NCORES-1:0] sc_ok;
    mem_pkg::word_t      [NCORES-1:0] core_addr;

    for (genvar i = 0; i < NCORES; i++) begin : gen_core
        assign core_addr[i] = req_data_i[i].addr;  // reservation compare address

        bus_decoder #(
            .HART_ID(i)
        ) u_decoder (
            .clk_i       (clk_i),
            .rst         (rst),
            .req_i       (req_i[i]),
            .req_data_i  (req_data_i[i]),
            .sc_ok_i     (sc_ok[i]),
            .dmem_done_i (dmem_done[i]),
            .dmem_rdata_i(dmem_rdata[i]),
            .dmem_valid_o(dmem_valid[i]),
            .dmem_req_o  (dmem_req[i]),
            .store_o     (store[i]),
            .lr_o        (lr[i]),
            .sc_o        (sc[i]),
            .done_o      (done_o[i]),
            .resp_o      (resp_o[i])
        );
    end

    dmem_arbiter #(
        .NCORES    (NCORES),
        .DMEM_WORDS(DMEM_WORDS)
    ) u_arbiter (
        .clk_i  (clk_i),
        .rst    (rst),
        .valid_i(dmem_valid),
        .req_i  (dmem_req),
        .done_o (dmem_done),
        .rdata_o(dmem_rdata)
    );

    lrsc_monitor #(
        .NCORES(NCORES)
    ) u_lrsc (
        .clk_i  (clk_i),
        .rst    (rst),
        .lr_i   (lr),
        .sc_i   (sc),
        .store_i(store),
        .addr_i (core_addr),
        .sc_ok_o(sc_ok)
    );

endmodule

`default_nettype wire

/* test/mem_subsystem_assert.sv */
// concurrent checks on the per-core done pulse, bound into the memory subsystem top level
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_assert #(
    parameter int unsigned NCORES = 2
) (
    input logic              clk_i,
    input logic              rst,
    input logic [NCORES-1:0] req_i,
    input logic [NCORES-1:0] done_i
);

    int unsigned fail_count = 0;  // failed checks so far

    for (genvar i = 0; i < NCORES; i++) begin : gen_core
        // done answers a request held up to the edge that raised it
        assert property (@(posedge clk_i) disable iff (rst) done_i[i] |-> $past(req_i[i]))
            else begin
                $error("core %0d raised done without a pending request", i);
                fail_count++;
            end

        assert property (@(posedge clk_i) disable iff (rst) done_i[i] |=> !done_i[i])
            else begin
                $error("core %0d held done for more than one cycle", i);
                fail_count++;
            end
    end

    // first cycle out of reset stays quiet
    assert property (@(posedge clk_i) $fell(rst) |-> (done_i == '0) ##1 (done_i == '0))
        else begin
            $error("done raised in the cycle after reset");
            fail_count++;
        end

endmodule

bind mem_subsystem mem_subsystem_assert #(
    .NCORES(NCORES)
) u_assert (
    .clk_i (clk_i),
    .rst   (rst),
    .req_i (req_i),
    .done_i(done_o)
);

`default_nettype wire

/* test/tb_mem_subsystem.sv */
// table-driven testbench with model memory, reservation model, LCG data and compare tasks
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

    localparam int unsigned NCORES     = 2;
    localparam int unsigned DMEM_WORDS = 1024;
    localparam int          TIMEOUT    = 50;  // cycles per wait for done

    localparam mem_pkg::word_t DMEM_BASE = 32'h1000_0000;
    localparam mem_pkg::word_t PERF_BASE = 32'h4000_0000;
    localparam mem_pkg::word_t HART_ADDR = 32'h4000_1000;

    typedef enum {CHK_NONE, CHK_WORD, CHK_SC, CHK_RISE} check_e;

    typedef struct {
        string              name;
        int                 core;
        mem_pkg::core_req_t req;
        mem_pkg::word_t     exp_rdata;
        logic               exp_sc_ok;
        check_e             kind;
        bit                 with_next;  // issued in the same cycle as the next entry
    } vec_t;

    logic                              clk_i;
    logic                              rst;
    logic                [NCORES-1:0]  req;
    mem_pkg::core_req_t  [NCORES-1:0]  req_data;
    logic                [NCORES-1:0]  done;
    mem_pkg::core_resp_t [NCORES-1:0]  resp;

    vec_t           table_q[$];
    mem_pkg::word_t model_mem [DMEM_WORDS];
    bit             resv_valid [NCORES];
    logic [29:0]    resv_word [NCORES];   // reserved word address
    mem_pkg::word_t last_rdata [NCORES];
    mem_pkg::word_t lcg_state;

    mem_subsystem #(
        .NCORES    (NCORES),
        .DMEM_WORDS(DMEM_WORDS)
    ) UUT (
        .clk_i     (clk_i),
        .rst       (rst),
        .req_i     (req),
        .req_data_i(req_data),
        .done_o    (done),
        .resp_o    (resp)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic mem_pkg::word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic mem_pkg::word_t dmem_addr(int word);
        return DMEM_BASE + mem_pkg::word_t'(word * 4);
    endfunction

    // expected response from the memory map and the LR/SC rules
    function automatic void add_entry(string name, int core, logic we,
                                      mem_pkg::atomic_op_e op, mem_pkg::word_t addr,
                                      mem_pkg::word_t wdata, mem_pkg::strb_t wstrb,
                                      check_e kind, bit with_next);
        vec_t v;
        int   idx;
        logic ok;
        v.name      = name;
        v.core      = core;
        v.req.we    = we;
        v.req.op    = op;
        v.req.addr  = addr;
        v.req.wdata = wdata;
        v.req.wstrb = wstrb;
        v.exp_rdata = '0;      // perf (when stopped) and unmapped read zero
        v.exp_sc_ok = 1'b0;
        v.kind      = kind;
        v.with_next = with_next;
        if (addr[30:28] == 3'b001) begin
            idx         = int'(addr[11:2]);
            v.exp_rdata = model_mem[idx];  // word before any write
            ok          = 1'b1;
            if (op == mem_pkg::OP_SC) begin
                ok                = resv_valid[core] && resv_word[core] == addr[31:2];
                resv_valid[core]  = 1'b0;
                v.exp_sc_ok       = ok;
            end
            if (op == mem_pkg::OP_LR) begin
                resv_valid[core] = 1'b1;
                resv_word[core]  = addr[31:2];
            end
            if (we && ok) begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) begin
                        model_mem[idx][8*b +: 8] = wdata[8*b +: 8];
                    end
                end
                for (int c = 0; c < NCORES; c++) begin
                    if (c != core && resv_word[c] == addr[31:2]) begin
                        resv_valid[c] = 1'b0;  // other core's reservation broken
                    end
                end
            end
        end else if (addr[30:28] == 3'b100 && addr[12]) begin
            v.exp_rdata = mem_pkg::word_t'(core);
        end
        table_q.push_back(v);
    endfunction

    function automatic void add_write(string name, int core, mem_pkg::word_t addr,
                                      mem_pkg::strb_t wstrb, bit with_next);
        add_entry(name, core, 1'b1, mem_pkg::OP_PLAIN, addr, lcg_next(), wstrb,
                  CHK_NONE, with_next);
    endfunction

    function automatic void add_read(string name, int core, mem_pkg::word_t addr,
                                     check_e kind, bit with_next);
        add_entry(name, core, 1'b0, mem_pkg::OP_PLAIN, addr, '0, '0, kind, with_next);
    endfunction

    function automatic void build_table();
        for (int w = 0; w < 4; w++) begin
            add_write($sformatf("wr_full_%0d", w), 0, dmem_addr(w), 4'hF, 1'b0);
        end
        add_write("wr_strb_lo", 1, dmem_addr(1), 4'b0101, 1'b0);
        add_write("wr_strb_hi", 0, dmem_addr(2), 4'b1000, 1'b0);
        add_write("wr_strb_mid", 1, dmem_addr(3), 4'b0110, 1'b0);
        for (int w = 0; w < 4; w++) begin
            add_read($sformatf("rd_word_%0d", w), w % 2, dmem_addr(w), CHK_WORD, 1'b0);
        end
        add_write("pair_wr_c0", 0, dmem_addr(10), 4'hF, 1'b1);
        add_write("pair_wr_c1", 1, dmem_addr(11), 4'hF, 1'b0);
        add_read("pair_rd_c0", 0, dmem_addr(11), CHK_WORD, 1'b1);
        add_read("pair_rd_c1", 1, dmem_addr(10), CHK_WORD, 1'b0);
        add_write("same_wr_c0", 0, dmem_addr(12), 4'b0001, 1'b1);  // own byte lane
        add_write("same_wr_c1", 1, dmem_addr(12), 4'b0100, 1'b0);
        add_read("same_rd_c0", 0, dmem_addr(12), CHK_WORD, 1'b1);
        add_read("same_rd_c1", 1, dmem_addr(12), CHK_WORD, 1'b0);
        add_read("hart_c0", 0, HART_ADDR, CHK_WORD, 1'b1);
        add_read("hart_c1", 1, HART_ADDR, CHK_WORD, 1'b0);
        add_write("unmapped_wr", 0, 32'h2000_0040, 4'hF, 1'b0);
        add_read("unmapped_rd", 0, 32'h2000_0040, CHK_WORD, 1'b0);
        add_read("unmapped_low", 1, 32'h0000_0100, CHK_WORD, 1'b0);
        add_entry("perf_run", 0, 1'b1, mem_pkg::OP_PLAIN, PERF_BASE, 32'd1, 4'hF,
                  CHK_NONE, 1'b0);
        add_read("perf_lo_a", 0, PERF_BASE + 32'h4, CHK_NONE, 1'b0);
        add_read("perf_lo_b", 0, PERF_BASE + 32'h4, CHK_RISE, 1'b0);
        add_entry("perf_stop", 0, 1'b1, mem_pkg::OP_PLAIN, PERF_BASE, 32'd0, 4'hF,
                  CHK_NONE, 1'b0);
        add_read("perf_zero", 0, PERF_BASE + 32'h4, CHK_WORD, 1'b0);
        add_entry("lr_a", 0, 1'b0, mem_pkg::OP_LR, dmem_addr(20), '0, '0, CHK_WORD, 1'b0);
        add_entry("sc_a", 0, 1'b1, mem_pkg::OP_SC, dmem_addr(20), lcg_next(), 4'hF,
                  CHK_SC, 1'b0);
        add_read("sc_a_data", 1, dmem_addr(20), CHK_WORD, 1'b0);
        add_entry("lr_b", 0, 1'b0, mem_pkg::OP_LR, dmem_addr(21), '0, '0, CHK_WORD, 1'b0);
        add_write("steal_b", 1, dmem_addr(21), 4'hF, 1'b0);
        add_entry("sc_b", 0, 1'b1, mem_pkg::OP_SC, dmem_addr(21), lcg_next(), 4'hF,
                  CHK_SC, 1'b0);
        add_read("sc_b_data", 0, dmem_addr(21), CHK_WORD, 1'b0);
        add_entry("sc_again", 0, 1'b1, mem_pkg::OP_SC, dmem_addr(20), lcg_next(), 4'hF,
                  CHK_SC, 1'b0);
        add_read("sc_again_data", 0, dmem_addr(20), CHK_WORD, 1'b0);
    endfunction

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_word(string name, mem_pkg::word_t expected, mem_pkg::word_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %08h actual %08h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %b actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_result(vec_t v, mem_pkg::core_resp_t r);
        case (v.kind)
            CHK_WORD: check_word(v.name, v.exp_rdata, r.rdata);
            CHK_SC:   check_flag(v.name, v.exp_sc_ok, r.sc_ok);
            CHK_RISE: check_flag(v.name, 1'b1, r.rdata > last_rdata[v.core]);
            default:  ;
        endcase
        last_rdata[v.core] = r.rdata;
    endtask

    // drive one or two entries together and wait for every done
    task automatic apply_group(int first, int count);
        logic [NCORES-1:0] waiting;
        int                cycles;
        vec_t              v;
        @(negedge clk_i);  // previous done cycle is over
        waiting = '0;
        for (int k = first; k < first + count; k++) begin
            v                = table_q[k];
            req_data[v.core] = v.req;
            req[v.core]      = 1'b1;
            waiting[v.core]  = 1'b1;
        end
        cycles = 0;
        while (waiting != '0) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timeout, no done within %0d cycles for %s", TIMEOUT,
                         table_q[first].name);
                abort_run();
            end
            for (int k = first; k < first + count; k++) begin
                v = table_q[k];
                if (waiting[v.core] && done[v.core]) begin
                    waiting[v.core] = 1'b0;
                    req[v.core]     = 1'b0;
                    check_result(v, resp[v.core]);
                end
            end
        end
    endtask

    always @(UUT.u_assert.fail_count) begin
        if (UUT.u_assert.fail_count != 0) begin
            $display("a protocol assertion on the done pulse failed");
            abort_run();
        end
    end

    initial begin
        int n;
        int cnt;
        rst       = 1'b1;
        req       = '0;
        req_data  = '0;
        lcg_state = 32'd42;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            model_mem[i] = '0;  // RAM starts cleared
        end
        for (int c = 0; c < NCORES; c++) begin
            resv_valid[c] = 1'b0;
            resv_word[c]  = '0;
            last_rdata[c] = '0;
        end
        build_table();
        repeat (4) @(negedge clk_i);
        rst = 1'b0;
        repeat (2) @(negedge clk_i);
        n = 0;
        while (n < table_q.size()) begin
            cnt = table_q[n].with_next ? 2 : 1;
            apply_group(n, cnt);
            n += cnt;
        end
        if (UUT.u_assert.fail_count != 0) begin
            $display("a protocol assertion on the done pulse failed");
            abort_run();
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* compile.f */
design/mem_pkg.sv
design/dmem_ram.sv
design/dmem_arbiter.sv
design/perf_counter.sv
design/lrsc_monitor.sv
design/bus_decoder.sv
design/mem_subsystem.sv
test/mem_subsystem_assert.sv
test/tb_mem_subsystem.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - files:
      - design/mem_pkg.sv
      - design/dmem_ram.sv
      - design/dmem_arbiter.sv
      - design/perf_counter.sv
      - design/lrsc_monitor.sv
      - design/bus_decoder.sv
      - design/mem_subsystem.sv
  - target: test
    files:
      - test/mem_subsystem_assert.sv
      - test/tb_mem_subsystem.sv
